/* Bender.yml */
package:
  name: id_tracker

sources:
  - source/id_pkg.sv
  - source/meta_table.sv
  - source/id_alloc.sv
  - source/wb_pending_set.sv
  - source/retire_select.sv
  - source/id_tracker_top.sv
  - target: test
    files:
      - verif/id_tracker_chk.sv
      - verif/tb_monitor.sv
      - verif/tb_top.sv

/* all.f */
source/id_pkg.sv
source/meta_table.sv
source/id_alloc.sv
source/wb_pending_set.sv
source/retire_select.sv
source/id_tracker_top.sv
verif/id_tracker_chk.sv
verif/tb_monitor.sv
verif/tb_top.sv

/* source/id_alloc.sv */
// Instruction ID allocator
`default_nettype none

module id_alloc
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_flush,
    input  logic      pc_id_assigned,
    input  logic      fetch_complete,
    input  logic      decode_advance,
    input  logic      issue_valid,
    input  logic [1:0] retire_count_next,
    output id_t       pc_id,
    output id_t       fetch_id,
    output id_t       decode_id,
    output logic      pc_id_available,
    output logic      decode_valid,
    output id_count_t post_issue_count
);

    id_t oldest_pre_issue_id;
    id_t oldest_pre_issue_id_next;

    // Negative so the MSB reads as "something fetched but not decoded"
    id_count_t fetched_count_neg;
    id_count_t pre_issue_count;
    id_count_t pre_issue_count_next;
    id_count_t post_issue_count_next;
    id_count_t inflight_count;

    ////////////////////////////////////////////////////////////
    // Pointers

    // Oldest ID not yet issued, includes an issue in this cycle
    assign oldest_pre_issue_id_next = oldest_pre_issue_id + id_t'(issue_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            oldest_pre_issue_id <= '0;
        end else begin
            oldest_pre_issue_id <= oldest_pre_issue_id_next;
        end
    end

    // Flush rewinds all front-end pointers to the oldest un-issued ID
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id <= '0;
            fetch_id <= '0;
            decode_id <= '0;
        end else if (fetch_flush) begin
            pc_id <= oldest_pre_issue_id_next;
            fetch_id <= oldest_pre_issue_id_next;
            decode_id <= oldest_pre_issue_id_next;
        end else begin
            pc_id <= pc_id + id_t'(pc_id_assigned);
            fetch_id <= fetch_id + id_t'(fetch_complete);
            decode_id <= decode_id + id_t'(decode_advance);
        end
    end

    ////////////////////////////////////////////////////////////
    // Counters

    // Fetched minus decoded, negated
    always_ff @(posedge clk) begin
        if (rst || fetch_flush) begin
            fetched_count_neg <= '0;
        end else begin
            fetched_count_neg <= fetched_count_neg + id_count_t'(decode_advance)
                - id_count_t'(fetch_complete);
        end
    end

    // Pre-issue part is dropped on a flush
    assign pre_issue_count_next = pre_issue_count + id_count_t'(pc_id_assigned)
        - id_count_t'(issue_valid);

    always_ff @(posedge clk) begin
        if (rst || fetch_flush) begin
            pre_issue_count <= '0;
        end else begin
            pre_issue_count <= pre_issue_count_next;
        end
    end

    // Post-issue part only shrinks on retire
    assign post_issue_count_next = post_issue_count + id_count_t'(issue_valid)
        - id_count_t'(retire_count_next);

    always_ff @(posedge clk) begin
        if (rst) begin
            post_issue_count <= '0;
        end else begin
            post_issue_count <= post_issue_count_next;
        end
    end

    // Total in flight, MSB set when all IDs are taken
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else if (fetch_flush) begin
            inflight_count <= post_issue_count_next;
        end else begin
            inflight_count <= pre_issue_count_next + post_issue_count_next;
        end
    end

    assign pc_id_available = ~inflight_count[LOG2_MAX_IDS];
    assign decode_valid = fetched_count_neg[LOG2_MAX_IDS];

endmodule

`default_nettype wire

/* source/id_pkg.sv */
// Instruction ID tracker definitions
`default_nettype none

package id_pkg;

    ////////////////////////////////////////////////////////////
    // ID space
    localparam int LOG2_MAX_IDS = 3;
    localparam int MAX_IDS = 2 ** LOG2_MAX_IDS;

    // One instruction ID
    typedef logic [LOG2_MAX_IDS-1:0] id_t;

    // Count of IDs, extra top bit used as a full/valid flag
    typedef logic [LOG2_MAX_IDS:0] id_count_t;

    ////////////////////////////////////////////////////////////
    // Stage packets

    // Next instruction offered to decode
    typedef struct packed {
        logic        valid;
        id_t         id;
        logic [31:0] pc;
        logic [31:0] instruction;
    } decode_packet_t;

    // Issue strobe
    typedef struct packed {
        logic valid;
        id_t  id;
        logic is_multicycle;
    } issue_packet_t;

    // Writeback strobe from multicycle units
    typedef struct packed {
        logic valid;
        id_t  id;
    } wb_packet_t;

    // Block retired in one cycle, up to three instructions
    typedef struct packed {
        logic [1:0] count;
        logic       rd_valid;
        id_t        rd_id;
    } retire_packet_t;

endpackage

`default_nettype wire

/* source/id_tracker_top.sv */
// Instruction ID tracker
`default_nettype none

module id_tracker_top
    import id_pkg::*;
#(
    parameter int RETIRE_PORTS = 2
) (
    input  logic           clk,
    input  logic           rst,
    // Fetch
    output id_t            pc_id,
    output logic           pc_id_available,
    input  logic [31:0]    if_pc,
    input  logic           pc_id_assigned,
    output id_t            fetch_id,
    input  logic           fetch_complete,
    input  logic [31:0]    fetch_instruction,
    // Decode
    output decode_packet_t decode,
    input  logic           decode_advance,
    input  logic           decode_uses_rd,
    input  logic [4:0]     decode_rd_addr,
    // Issue and writeback
    input  issue_packet_t  issue,
    input  wb_packet_t     wb,
    // Control
    input  logic           fetch_flush,
    input  logic           retire_hold,
    // Retire
    output retire_packet_t retire,
    output id_count_t      post_issue_count
);

    id_t         decode_id;
    logic        decode_valid;
    id_t         decode_raddr [1];
    logic [31:0] pc_rdata [1];
    logic [31:0] instr_rdata [1];
    id_t         retire_ids_next [RETIRE_PORTS];
    logic        retire_uses_rd [RETIRE_PORTS];
    logic        retire_pending [RETIRE_PORTS];
    logic [1:0]  retire_count_next;

    assign decode_raddr[0] = decode_id;

    ////////////////////////////////////////////////////////////
    // ID management
    id_alloc i_id_alloc (
        .clk               (clk),
        .rst               (rst),
        .fetch_flush       (fetch_flush),
        .pc_id_assigned    (pc_id_assigned),
        .fetch_complete    (fetch_complete),
        .decode_advance    (decode_advance),
        .issue_valid       (issue.valid),
        .retire_count_next (retire_count_next),
        .pc_id             (pc_id),
        .fetch_id          (fetch_id),
        .decode_id         (decode_id),
        .pc_id_available   (pc_id_available),
        .decode_valid      (decode_valid),
        .post_issue_count  (post_issue_count)
    );

    ////////////////////////////////////////////////////////////
    // Metadata tables

    // PC, written on ID assignment
    meta_table #(
        .DEPTH          (MAX_IDS),
        .NUM_READ_PORTS (1),
        .payload_t      (logic [31:0])
    ) i_pc_table (
        .clk   (clk),
        .we    (pc_id_assigned),
        .waddr (pc_id),
        .wdata (if_pc),
        .raddr (decode_raddr),
        .rdata (pc_rdata)
    );

    // Instruction word, written when fetch completes
    meta_table #(
        .DEPTH          (MAX_IDS),
        .NUM_READ_PORTS (1),
        .payload_t      (logic [31:0])
    ) i_instr_table (
        .clk   (clk),
        .we    (fetch_complete),
        .waddr (fetch_id),
        .wdata (fetch_instruction),
        .raddr (decode_raddr),
        .rdata (instr_rdata)
    );

    // Register write flag, x0 never counts as a write
    meta_table #(
        .DEPTH          (MAX_IDS),
        .NUM_READ_PORTS (RETIRE_PORTS),
        .payload_t      (logic)
    ) i_uses_rd_table (
        .clk   (clk),
        .we    (decode_advance),
        .waddr (decode_id),
        .wdata (decode_uses_rd & (|decode_rd_addr)),
        .raddr (retire_ids_next),
        .rdata (retire_uses_rd)
    );

    ////////////////////////////////////////////////////////////
    // Writeback tracking and retire
    wb_pending_set #(
        .NUM_READ_PORTS (RETIRE_PORTS)
    ) i_wb_pending_set (
        .clk         (clk),
        .rst         (rst),
        .set_valid   (issue.valid & issue.is_multicycle),
        .set_id      (issue.id),
        .clear_valid (wb.valid),
        .clear_id    (wb.id),
        .read_id     (retire_ids_next),
        .pending     (retire_pending)
    );

    retire_select #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) i_retire_select (
        .clk               (clk),
        .rst               (rst),
        .retire_hold       (retire_hold),
        .post_issue_count  (post_issue_count),
        .pending           (retire_pending),
        .uses_rd           (retire_uses_rd),
        .retire_ids_next   (retire_ids_next),
        .retire_count_next (retire_count_next),
        .retire            (retire)
    );

    // Decode view of the tables
    assign decode.valid = decode_valid;
    assign decode.id = decode_id;
    assign decode.pc = pc_rdata[0];
    assign decode.instruction = instr_rdata[0];

endmodule

`default_nettype wire

/* source/meta_table.sv */
// Per-ID metadata table
`default_nettype none

module meta_table
    import id_pkg::*;
#(
    parameter int  DEPTH = MAX_IDS,
    parameter int  NUM_READ_PORTS = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     we,
    input  id_t      waddr,
    input  payload_t wdata,
    input  id_t      raddr [NUM_READ_PORTS],
    output payload_t rdata [NUM_READ_PORTS]
);

    // Small LUT-RAM style storage
    payload_t table_mem [DEPTH];

    // Single write port updated at the edge
    always_ff @(posedge clk) begin
        if (we) begin
            table_mem[waddr] <= wdata;
        end
    end

    // One asynchronous read per port
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            rdata[i] = table_mem[raddr[i]];
        end
    end

endmodule

`default_nettype wire

/* source/retire_select.sv */
// Retire block selection
`default_nettype none

module retire_select
    import id_pkg::*;
#(
    parameter int RETIRE_PORTS = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           retire_hold,
    input  id_count_t      post_issue_count,
    input  logic           pending [RETIRE_PORTS],
    input  logic           uses_rd [RETIRE_PORTS],
    output id_t            retire_ids_next [RETIRE_PORTS],
    output logic [1:0]     retire_count_next,
    output retire_packet_t retire
);

    logic port_valid [RETIRE_PORTS];
    logic rd_found;
    logic contiguous;
    id_t  rd_id_next;

    ////////////////////////////////////////////////////////////
    // Port selection

    // Block is contiguous from port 0 and holds at most one rd writer
    always_comb begin
        contiguous = ~retire_hold;
        rd_found = 1'b0;
        rd_id_next = retire_ids_next[0];
        retire_count_next = '0;
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            // Issued, writeback done, and every earlier port going
            port_valid[i] = contiguous && (post_issue_count > id_count_t'(i))
                && !pending[i] && !(uses_rd[i] && rd_found);
            // First writer in the block names the rd ID
            if (port_valid[i] && uses_rd[i] && !rd_found) begin
                rd_id_next = retire_ids_next[i];
            end
            rd_found = rd_found | (port_valid[i] & uses_rd[i]);
            contiguous = contiguous & port_valid[i];
            retire_count_next = retire_count_next + 2'(port_valid[i]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Retire IDs

    // Port i trails the oldest unretired ID by i
    always_ff @(posedge clk) begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            if (rst) begin
                retire_ids_next[i] <= id_t'(i);
            end else begin
                retire_ids_next[i] <= retire_ids_next[i] + id_t'(retire_count_next);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered retire packet
    always_ff @(posedge clk) begin
        if (rst) begin
            retire <= '0;
        end else begin
            retire.count <= retire_count_next;
            retire.rd_valid <= rd_found;
            retire.rd_id <= rd_id_next;
        end
    end

endmodule

`default_nettype wire

/* source/wb_pending_set.sv */
// Writeback pending set
`default_nettype none

module wb_pending_set
    import id_pkg::*;
#(
    parameter int NUM_READ_PORTS = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic set_valid,
    input  id_t  set_id,
    input  logic clear_valid,
    input  id_t  clear_id,
    input  id_t  read_id [NUM_READ_PORTS],
    output logic pending [NUM_READ_PORTS]
);

    ////////////////////////////////////////////////////////////
    // Toggle banks

    // One bank per write port, so each port only flips its own bit
    logic [MAX_IDS-1:0] set_bank;
    logic [MAX_IDS-1:0] clear_bank;

    // Issue of a multicycle ID
    always_ff @(posedge clk) begin
        if (rst) begin
            set_bank <= '0;
        end else if (set_valid) begin
            set_bank[set_id] <= ~set_bank[set_id];
        end
    end

    // Writeback of that ID
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_bank <= '0;
        end else if (clear_valid) begin
            clear_bank[clear_id] <= ~clear_bank[clear_id];
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports

    // Pending while the banks disagree
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            pending[i] = set_bank[read_id[i]] ^ clear_bank[read_id[i]];
        end
    end

endmodule

`default_nettype wire

/* verif/id_tracker_chk.sv */
// Tracker protocol assertions
`default_nettype none

module id_tracker_chk
    import id_pkg::*;
(
    input logic           clk,
    input logic           rst,
    input logic           pc_id_available,
    input logic           pc_id_assigned,
    input decode_packet_t decode,
    input logic           decode_advance,
    input logic           retire_hold,
    input retire_packet_t retire
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failure tally for the end-of-run summary
    int assert_failures = 0;

    // ID assignment needs a free ID
    assign_needs_free_id : assert property (
        @(posedge clk) disable iff (rst) pc_id_assigned |-> pc_id_available
    ) else begin
        assert_failures++;
        $error("pc_id_assigned while no ID is available");
    end

    // Decode only advances over a valid instruction
    advance_needs_valid : assert property (
        @(posedge clk) disable iff (rst) decode_advance |-> decode.valid
    ) else begin
        assert_failures++;
        $error("decode_advance while decode.valid is low");
    end

    // Held retire shows an empty block one cycle later
    hold_blocks_retire : assert property (
        @(posedge clk) disable iff (rst) retire_hold |=> (retire.count == 2'd0)
    ) else begin
        assert_failures++;
        $error("retire.count nonzero after a cycle with retire_hold");
    end

endmodule

`default_nettype wire

/* verif/tb_monitor.sv */
// Tracker reference model and checker
`default_nettype none

module tb_monitor
    import id_pkg::*;
#(
    parameter int RETIRE_PORTS = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  id_t            pc_id,
    input  logic           pc_id_available,
    input  logic [31:0]    if_pc,
    input  logic           pc_id_assigned,
    input  id_t            fetch_id,
    input  logic           fetch_complete,
    input  logic [31:0]    fetch_instruction,
    input  decode_packet_t decode,
    input  logic           decode_advance,
    input  logic           decode_uses_rd,
    input  logic [4:0]     decode_rd_addr,
    input  issue_packet_t  issue,
    input  wb_packet_t     wb,
    input  logic           fetch_flush,
    input  logic           retire_hold,
    input  retire_packet_t retire,
    input  id_count_t      post_issue_count,
    output int             decode_errs,
    output int             alloc_errs,
    output int             retire_errs,
    output int             issued_total,
    output int             retired_total
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CAT_DECODE = 0;
    localparam int CAT_ALLOC = 1;
    localparam int CAT_RETIRE = 2;

    ////////////////////////////////////////////////////////////
    // Shadow state, as it stands after the last rising edge

    logic [31:0]    pc_shadow [MAX_IDS];
    logic [31:0]    instr_shadow [MAX_IDS];
    logic           uses_rd_shadow [MAX_IDS];
    // Issued multicycle IDs still waiting for writeback
    logic           pend [MAX_IDS];
    // Issued and not yet retired, oldest first
    id_t            issued_q [$];
    id_t            exp_pc_id;
    id_t            exp_fetch_id;
    id_t            exp_decode_id;
    id_t            oldest_unissued;
    int             pre_issue;
    int             fetched_count;
    // Block the DUT registers at the coming edge
    retire_packet_t exp_retire;

    // Decode offer from the shadow tables
    function automatic decode_packet_t expected_decode();
        decode_packet_t pkt;
        pkt.valid = (fetched_count > 0);
        pkt.id = exp_decode_id;
        pkt.pc = pc_shadow[exp_decode_id];
        pkt.instruction = instr_shadow[exp_decode_id];
        return pkt;
    endfunction

    // Oldest issued IDs in order, stop at a pending one or a second rd writer
    function automatic retire_packet_t expected_retire(input logic hold);
        retire_packet_t pkt;
        logic           go;
        id_t            cand_id;
        pkt = '0;
        go = !hold;
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            if (go && (i < issued_q.size())) begin
                cand_id = issued_q[i];
                if (pend[cand_id] || (uses_rd_shadow[cand_id] && pkt.rd_valid)) begin
                    go = 1'b0;
                end else begin
                    pkt.count = pkt.count + 2'd1;
                    if (uses_rd_shadow[cand_id]) begin
                        pkt.rd_valid = 1'b1;
                        pkt.rd_id = cand_id;
                    end
                end
            end else begin
                go = 1'b0;
            end
        end
        return pkt;
    endfunction

    task automatic check_field(input string name, input int cat,
                               input logic [31:0] exp_val, input logic [31:0] got_val);
        if (exp_val !== got_val) begin
            $display("ERR %0t %s exp %0h got %0h", $time, name, exp_val, got_val);
            case (cat)
                CAT_DECODE: decode_errs++;
                CAT_ALLOC:  alloc_errs++;
                default:    retire_errs++;
            endcase
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < MAX_IDS; i++) begin
            pend[i] = 1'b0;
            uses_rd_shadow[i] = 1'b0;
        end
        issued_q.delete();
        exp_pc_id = '0;
        exp_fetch_id = '0;
        exp_decode_id = '0;
        oldest_unissued = '0;
        pre_issue = 0;
        fetched_count = 0;
        exp_retire = '0;
        decode_errs = 0;
        alloc_errs = 0;
        retire_errs = 0;
        issued_total = 0;
        retired_total = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Output comparison
    task automatic compare_outputs();
        decode_packet_t exp_dec;
        logic           exp_avail;
        exp_dec = expected_decode();
        exp_avail = ((pre_issue + issued_q.size()) < MAX_IDS);
        check_field("pc_id", CAT_ALLOC, 32'(exp_pc_id), 32'(pc_id));
        check_field("fetch_id", CAT_ALLOC, 32'(exp_fetch_id), 32'(fetch_id));
        check_field("pc_id_available", CAT_ALLOC, 32'(exp_avail), 32'(pc_id_available));
        check_field("post_issue_count", CAT_RETIRE, 32'(issued_q.size()),
                    32'(post_issue_count));
        check_field("decode.valid", CAT_DECODE, 32'(exp_dec.valid), 32'(decode.valid));
        if (exp_dec.valid) begin
            check_field("decode.id", CAT_DECODE, 32'(exp_dec.id), 32'(decode.id));
            check_field("decode.pc", CAT_DECODE, exp_dec.pc, decode.pc);
            check_field("decode.instruction", CAT_DECODE, exp_dec.instruction,
                        decode.instruction);
        end
        if (retire.count > RETIRE_PORTS) begin
            $display("Retire block of %0d IDs is wider than the %0d retire ports",
                     retire.count, RETIRE_PORTS);
            retire_errs++;
        end
        check_field("retire.count", CAT_RETIRE, 32'(exp_retire.count), 32'(retire.count));
        check_field("retire.rd_valid", CAT_RETIRE, 32'(exp_retire.rd_valid),
                    32'(retire.rd_valid));
        if (exp_retire.rd_valid) begin
            check_field("retire.rd_id", CAT_RETIRE, 32'(exp_retire.rd_id), 32'(retire.rd_id));
        end
        retired_total += retire.count;
    endtask

    ////////////////////////////////////////////////////////////
    // Model update with the inputs of the coming edge
    task automatic apply_inputs();
        if (issue.valid) begin
            issued_q.push_back(issue.id);
            pend[issue.id] = issue.is_multicycle;
            oldest_unissued = oldest_unissued + 1'b1;
            pre_issue--;
            issued_total++;
        end
        if (wb.valid) begin
            pend[wb.id] = 1'b0;
        end
        if (fetch_flush) begin
            // Rewind to the oldest un-issued ID, pre-issue work is gone
            exp_pc_id = oldest_unissued;
            exp_fetch_id = oldest_unissued;
            exp_decode_id = oldest_unissued;
            pre_issue = 0;
            fetched_count = 0;
        end else begin
            if (pc_id_assigned) begin
                pc_shadow[exp_pc_id] = if_pc;
                exp_pc_id = exp_pc_id + 1'b1;
                pre_issue++;
            end
            if (fetch_complete) begin
                instr_shadow[exp_fetch_id] = fetch_instruction;
                exp_fetch_id = exp_fetch_id + 1'b1;
                fetched_count++;
            end
            if (decode_advance) begin
                // x0 is never a register write
                uses_rd_shadow[exp_decode_id] = decode_uses_rd && (decode_rd_addr != 5'd0);
                exp_decode_id = exp_decode_id + 1'b1;
                fetched_count--;
            end
        end
    endtask

    // Mid-cycle sampling, inputs and outputs both settled
    always @(negedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            compare_outputs();
            exp_retire = expected_retire(retire_hold);
            repeat (exp_retire.count) begin
                void'(issued_q.pop_front());
            end
            apply_inputs();
        end
    end

endmodule

`default_nettype wire

/* verif/tb_top.sv */
// Testbench top for the ID tracker
`default_nettype none

module tb_top
    import id_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RETIRE_PORTS = 2;
    localparam int RUN_LEN = 400;
    localparam int TIMEOUT_CYCLES = RUN_LEN * 40;
    // Issue counts at which the front end is flushed
    localparam int FLUSH_AT_A = 130;
    localparam int FLUSH_AT_B = 270;

    logic           clk = 1'b0;
    logic           rst;
    id_t            pc_id;
    logic           pc_id_available;
    logic [31:0]    if_pc;
    logic           pc_id_assigned;
    id_t            fetch_id;
    logic           fetch_complete;
    logic [31:0]    fetch_instruction;
    decode_packet_t decode;
    logic           decode_advance;
    logic           decode_uses_rd;
    logic [4:0]     decode_rd_addr;
    issue_packet_t  issue;
    wb_packet_t     wb;
    logic           fetch_flush;
    logic           retire_hold;
    retire_packet_t retire;
    id_count_t      post_issue_count;

    int decode_errs;
    int alloc_errs;
    int retire_errs;
    int mon_issued;
    int mon_retired;
    int other_errs = 0;
    int cycle_count = 0;

    integer seed = 32'hcece;

    // Stage state on the testbench side
    int   fetch_pending;
    int   decoded_wait;
    int   pre_issue;
    int   issued;
    int   flushes;
    id_t  next_issue_id;
    logic wb_active [MAX_IDS];
    int   wb_delay [MAX_IDS];

    always #10 clk = ~clk;

    id_tracker_top #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) i_dut (
        .clk (clk), .rst (rst),
        .pc_id (pc_id), .pc_id_available (pc_id_available),
        .if_pc (if_pc), .pc_id_assigned (pc_id_assigned),
        .fetch_id (fetch_id), .fetch_complete (fetch_complete),
        .fetch_instruction (fetch_instruction),
        .decode (decode), .decode_advance (decode_advance),
        .decode_uses_rd (decode_uses_rd), .decode_rd_addr (decode_rd_addr),
        .issue (issue), .wb (wb),
        .fetch_flush (fetch_flush), .retire_hold (retire_hold),
        .retire (retire), .post_issue_count (post_issue_count)
    );

    tb_monitor #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) i_monitor (
        .clk (clk), .rst (rst),
        .pc_id (pc_id), .pc_id_available (pc_id_available),
        .if_pc (if_pc), .pc_id_assigned (pc_id_assigned),
        .fetch_id (fetch_id), .fetch_complete (fetch_complete),
        .fetch_instruction (fetch_instruction),
        .decode (decode), .decode_advance (decode_advance),
        .decode_uses_rd (decode_uses_rd), .decode_rd_addr (decode_rd_addr),
        .issue (issue), .wb (wb),
        .fetch_flush (fetch_flush), .retire_hold (retire_hold),
        .retire (retire), .post_issue_count (post_issue_count),
        .decode_errs (decode_errs), .alloc_errs (alloc_errs),
        .retire_errs (retire_errs), .issued_total (mon_issued),
        .retired_total (mon_retired)
    );

    bind id_tracker_top id_tracker_chk i_chk (
        .clk (clk), .rst (rst),
        .pc_id_available (pc_id_available), .pc_id_assigned (pc_id_assigned),
        .decode (decode), .decode_advance (decode_advance),
        .retire_hold (retire_hold), .retire (retire)
    );

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic int total_errors();
        return decode_errs + alloc_errs + retire_errs + other_errs
            + i_dut.i_chk.assert_failures;
    endfunction

    task automatic print_counts();
        $display("Errors: decode %0d, alloc %0d, retire %0d, assertions %0d, other %0d",
                 decode_errs, alloc_errs, retire_errs, i_dut.i_chk.assert_failures,
                 other_errs);
    endtask

    task automatic idle_inputs();
        pc_id_assigned = 1'b0;
        fetch_complete = 1'b0;
        decode_advance = 1'b0;
        issue = '0;
        wb = '0;
        fetch_flush = 1'b0;
        retire_hold = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stage models stepped once per cycle

    // Lowest due ID takes the single writeback slot
    task automatic send_writeback();
        for (int i = 0; i < MAX_IDS; i++) begin
            if (wb_active[i] && (wb_delay[i] > 0)) begin
                wb_delay[i]--;
            end
        end
        for (int i = 0; i < MAX_IDS; i++) begin
            if (!wb.valid && wb_active[i] && (wb_delay[i] == 0)) begin
                wb.valid = 1'b1;
                wb.id = id_t'(i);
                wb_active[i] = 1'b0;
            end
        end
    endtask

    task automatic drive_cycle();
        idle_inputs();
        retire_hold = (rand_below(8) == 0);
        send_writeback();
        if ((flushes < 2) && (issued == ((flushes == 0) ? FLUSH_AT_A : FLUSH_AT_B))) begin
            // Drop everything fetched or decoded but not issued
            fetch_flush = 1'b1;
            flushes++;
            fetch_pending = 0;
            decoded_wait = 0;
            pre_issue = 0;
        end else begin
            if ((decoded_wait > 0) && (rand_below(4) != 0)) begin
                issue.valid = 1'b1;
                issue.id = next_issue_id;
                issue.is_multicycle = (rand_below(3) == 0);
                if (issue.is_multicycle) begin
                    wb_active[next_issue_id] = 1'b1;
                    wb_delay[next_issue_id] = 1 + rand_below(6);
                end
                next_issue_id = next_issue_id + 1'b1;
                decoded_wait--;
                pre_issue--;
                issued++;
            end
            if (decode.valid && (rand_below(4) != 0)) begin
                decode_advance = 1'b1;
                decode_uses_rd = (rand_below(3) != 0);
                decode_rd_addr = (rand_below(4) == 0) ? 5'd0 : 5'(rand_below(32));
                decoded_wait++;
            end
            if ((fetch_pending > 0) && (rand_below(3) != 0)) begin
                fetch_complete = 1'b1;
                fetch_instruction = $random(seed);
                fetch_pending--;
            end
            if (pc_id_available && ((issued + pre_issue) < RUN_LEN)
                    && (rand_below(4) != 0)) begin
                pc_id_assigned = 1'b1;
                if_pc = 32'($random(seed)) & 32'hffff_fffc;
                fetch_pending++;
                pre_issue++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst = 1'b1;
        idle_inputs();
        if_pc = '0;
        fetch_instruction = '0;
        decode_uses_rd = 1'b0;
        decode_rd_addr = '0;
        fetch_pending = 0;
        decoded_wait = 0;
        pre_issue = 0;
        issued = 0;
        flushes = 0;
        next_issue_id = '0;
        for (int i = 0; i < MAX_IDS; i++) begin
            wb_active[i] = 1'b0;
            wb_delay[i] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!((issued == RUN_LEN) && (mon_retired >= RUN_LEN))) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end
        idle_inputs();
        repeat (3) @(posedge clk);
        if (mon_issued != mon_retired) begin
            $display("Issued count %0d and retired count %0d differ at the end of the run",
                     mon_issued, mon_retired);
            other_errs++;
        end
        print_counts();
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Run limit from the instruction count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
